// ==== rtl/eth_tx_pkg.sv ====
package eth_tx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [7:0]  len_t;          // ip payload bytes, 1 to 255.

    localparam ethertype_t ETH_TYPE_IP  = 16'h0800;
    localparam ethertype_t ETH_TYPE_ARP = 16'h0806;
    localparam byte_t      IP_PROTO_UDP = 8'h11;
    localparam byte_t      IP_TTL       = 8'h40;
    localparam int         ARP_HDR_LEN  = 28;
    localparam int         IP_HDR_LEN   = 20;

    // arp opcodes.
    localparam logic [15:0] ARP_OP_REQUEST = 16'd1;
    localparam logic [15:0] ARP_OP_REPLY   = 16'd2;

    typedef struct packed {
        mac_addr_t local_mac;
        ip_addr_t  local_ip;
    } net_cfg_t;

    typedef struct packed {
        logic [15:0] opcode;
        mac_addr_t   target_mac;
        ip_addr_t    target_ip;
    } arp_req_t;

    typedef struct packed {
        mac_addr_t dst_mac;
        ip_addr_t  dst_ip;
        len_t      len;
    } ip_req_t;

    typedef struct packed {
        byte_t data;
        logic  en;
        logic  last;
    } tx_out_t;

endpackage

// ==== rtl/mac_tx.sv ====
`timescale 1ns/1ps

module mac_tx (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_tx_pkg::mac_addr_t  src_mac,
    input  eth_tx_pkg::mac_addr_t  dst_mac,
    input  eth_tx_pkg::ethertype_t mac_mode,
    input  logic                   fs,
    output logic                   fd,
    output logic                   fs_ip,
    input  logic                   fd_ip,
    input  eth_tx_pkg::byte_t      ip_txd,
    output logic                   fs_arp,
    input  logic                   fd_arp,
    input  eth_tx_pkg::byte_t      arp_txd,
    output eth_tx_pkg::tx_out_t    tx
);

    typedef enum logic [4:0] {
        IDLE, WAIT,
        HD00, HD01, HD02, HD03, HD04, HD05, HD06,
        HD07, HD08, HD09, HD0A, HD0B, HD0C, HD0D,
        WORK, DONE
    } state_t;

    state_t            state;
    state_t            next_state;
    logic              mode_arp;
    logic              gen_on;
    logic              gen_fd;
    eth_tx_pkg::byte_t gen_txd;
    eth_tx_pkg::byte_t tx_data;
    logic              tx_en;
    logic              tx_last;

    assign mode_arp = (mac_mode == eth_tx_pkg::ETH_TYPE_ARP);

    // generator is started in HD0D so its first byte follows the ethertype.
    assign gen_on  = (state == HD0D) || (state == WORK);
    assign fs_arp  = gen_on && mode_arp;
    assign fs_ip   = gen_on && !mode_arp;
    assign gen_fd  = mode_arp ? fd_arp : fd_ip;
    assign gen_txd = mode_arp ? arp_txd : ip_txd;
    assign fd      = (state == DONE) && fs;    // held until fs drops.

    assign tx = '{data: tx_data, en: tx_en, last: tx_last};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: next_state = WAIT;
            WAIT: if (fs) next_state = HD00;
            HD00, HD01, HD02, HD03, HD04, HD05, HD06,
            HD07, HD08, HD09, HD0A, HD0B, HD0C: next_state = state_t'(state + 5'd1);
            HD0D: next_state = WORK;
            WORK: if (gen_fd) next_state = DONE;
            DONE: if (!fs) next_state = WAIT;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_en   <= 1'b0;
            tx_last <= 1'b0;
        end else begin
            tx_en   <= (state inside {[HD00:HD0D]}) || (state == WORK);
            tx_last <= (state == WORK) && gen_fd;
        end
    end

    // header msb first, then the generator stream.
    always_ff @(posedge clk) begin
        case (state)
            HD00: tx_data <= dst_mac[47:40];
            HD01: tx_data <= dst_mac[39:32];
            HD02: tx_data <= dst_mac[31:24];
            HD03: tx_data <= dst_mac[23:16];
            HD04: tx_data <= dst_mac[15:8];
            HD05: tx_data <= dst_mac[7:0];
            HD06: tx_data <= src_mac[47:40];
            HD07: tx_data <= src_mac[39:32];
            HD08: tx_data <= src_mac[31:24];
            HD09: tx_data <= src_mac[23:16];
            HD0A: tx_data <= src_mac[15:8];
            HD0B: tx_data <= src_mac[7:0];
            HD0C: tx_data <= mac_mode[15:8];
            HD0D: tx_data <= mac_mode[7:0];
            WORK: tx_data <= gen_txd;
            default: tx_data <= 8'h00;
        endcase
    end

endmodule

// ==== rtl/arp_tx.sv ====
`timescale 1ns/1ps

module arp_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_tx_pkg::net_cfg_t cfg,
    input  eth_tx_pkg::arp_req_t req,
    input  logic                 fs,
    output logic                 fd,
    output eth_tx_pkg::byte_t    txd
);

    typedef enum logic [1:0] {IDLE, BODY, DONE} state_t;

    state_t                                state;
    logic [4:0]                            cnt;      // index of the byte being sent.
    eth_tx_pkg::mac_addr_t                 tha;
    logic [8*eth_tx_pkg::ARP_HDR_LEN-1:0] body;

    // target mac unknown in a request.
    assign tha = (req.opcode == eth_tx_pkg::ARP_OP_REQUEST) ? '0 : req.target_mac;

    assign body = {16'h0001, eth_tx_pkg::ETH_TYPE_IP, 8'd6, 8'd4, req.opcode,
                   cfg.local_mac, cfg.local_ip, tha, req.target_ip};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
            fd    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (fs) begin
                        state <= BODY;
                        cnt   <= 5'd1;
                    end
                end
                BODY: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(eth_tx_pkg::ARP_HDR_LEN - 1)) begin
                        fd    <= 1'b1;                 // with the last byte.
                        state <= DONE;
                    end
                end
                default: begin
                    if (!fs) begin
                        state <= IDLE;
                        cnt   <= '0;
                        fd    <= 1'b0;
                    end
                end
            endcase
        end
    end

    // byte 0 goes out on the fs edge, so idle presents it too.
    always_ff @(posedge clk) begin
        if (state != DONE) begin
            txd <= body[8*(eth_tx_pkg::ARP_HDR_LEN - 1 - int'(cnt)) +: 8];
        end
    end

endmodule

// ==== rtl/ip_tx.sv ====
`timescale 1ns/1ps

module ip_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_tx_pkg::net_cfg_t cfg,
    input  eth_tx_pkg::ip_req_t  req,
    input  logic                 fs,
    output logic                 fd,
    output eth_tx_pkg::byte_t    txd,
    output logic                 pay_rd,
    input  eth_tx_pkg::byte_t    pay_data
);

    typedef enum logic [1:0] {IDLE, HDR, PAY, DONE} state_t;

    state_t                               state;
    logic [4:0]                           hcnt;
    eth_tx_pkg::len_t                     pcnt;
    logic [15:0]                          ident;
    logic [15:0]                          total_len;
    logic [15:0]                          csum;
    logic [15:0]                          csum_q;
    logic [8*eth_tx_pkg::IP_HDR_LEN-1:0] hdr_zero;    // checksum field zero.
    logic [8*eth_tx_pkg::IP_HDR_LEN-1:0] hdr;

    function automatic logic [15:0] ip_csum(input logic [8*eth_tx_pkg::IP_HDR_LEN-1:0] h);
        logic [31:0] acc;
        int          i;
        acc = '0;
        for (i = 0; i < eth_tx_pkg::IP_HDR_LEN / 2; i++) begin
            acc = acc + {16'h0000, h[16*i +: 16]};
        end
        // fold carries twice.
        acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
        acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
        return ~acc[15:0];
    endfunction

    assign total_len = 16'(eth_tx_pkg::IP_HDR_LEN) + {8'h00, req.len};
    assign hdr_zero  = {16'h4500, total_len, ident, 16'h4000, eth_tx_pkg::IP_TTL,
                        eth_tx_pkg::IP_PROTO_UDP, 16'h0000, cfg.local_ip, req.dst_ip};
    assign csum      = ip_csum(hdr_zero);
    assign hdr       = {hdr_zero[159:80], csum_q, hdr_zero[63:0]};

    // read one cycle ahead of the byte it feeds.
    assign pay_rd = ((state == HDR) && (hcnt == 5'(eth_tx_pkg::IP_HDR_LEN - 1))) ||
                    ((state == PAY) && (pcnt + 8'd1 != req.len));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            hcnt  <= '0;
            pcnt  <= '0;
            ident <= '0;
            fd    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (fs) begin
                        state <= HDR;
                        hcnt  <= 5'd1;
                    end
                end
                HDR: begin
                    hcnt <= hcnt + 5'd1;
                    if (hcnt == 5'(eth_tx_pkg::IP_HDR_LEN - 1)) begin
                        state <= PAY;
                        pcnt  <= '0;
                    end
                end
                PAY: begin
                    pcnt <= pcnt + 8'd1;
                    if (pcnt + 8'd1 == req.len) begin
                        fd    <= 1'b1;
                        state <= DONE;
                    end
                end
                default: begin
                    if (!fs) begin
                        state <= IDLE;
                        hcnt  <= '0;
                        fd    <= 1'b0;
                        ident <= ident + 16'd1;   // next frame id.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && fs) csum_q <= csum;
        case (state)
            IDLE: txd <= hdr[8*eth_tx_pkg::IP_HDR_LEN-1 -: 8];
            HDR: txd <= hdr[8*(eth_tx_pkg::IP_HDR_LEN - 1 - int'(hcnt)) +: 8];
            PAY: txd <= pay_data;
            default: txd <= txd;
        endcase
    end

endmodule

// ==== rtl/tx_sched.sv ====
`timescale 1ns/1ps

module tx_sched (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_tx_pkg::arp_req_t   arp_req,
    input  logic                   arp_valid,
    output logic                   arp_ready,
    input  eth_tx_pkg::ip_req_t    ip_req,
    input  logic                   ip_valid,
    output logic                   ip_ready,
    output logic                   fs,
    input  logic                   fd,
    output eth_tx_pkg::ethertype_t mac_mode,
    output eth_tx_pkg::mac_addr_t  dst_mac,
    output eth_tx_pkg::arp_req_t   arp_cur,
    output eth_tx_pkg::ip_req_t    ip_cur
);

    typedef enum logic [1:0] {PICK_NONE, PICK_ARP, PICK_IP} pick_t;

    pick_t                pick;
    logic                 arp_full;
    logic                 ip_full;
    logic                 arp_full_n;
    logic                 ip_full_n;
    eth_tx_pkg::arp_req_t arp_slot;
    eth_tx_pkg::ip_req_t  ip_slot;

    // arp first; framer must have released fd.
    always_comb begin
        pick = PICK_NONE;
        if (!fs && !fd) begin
            if (arp_full) pick = PICK_ARP;
            else if (ip_full) pick = PICK_IP;
        end
    end

    assign arp_full_n = (arp_full && pick != PICK_ARP) || (arp_valid && arp_ready);
    assign ip_full_n  = (ip_full && pick != PICK_IP) || (ip_valid && ip_ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arp_full  <= 1'b0;
            ip_full   <= 1'b0;
            arp_ready <= 1'b0;
            ip_ready  <= 1'b0;
            fs        <= 1'b0;
        end else begin
            arp_full  <= arp_full_n;
            ip_full   <= ip_full_n;
            arp_ready <= !arp_full_n;
            ip_ready  <= !ip_full_n;
            if (pick != PICK_NONE) fs <= 1'b1;
            else if (fd) fs <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arp_valid && arp_ready) arp_slot <= arp_req;
        if (ip_valid && ip_ready) ip_slot <= ip_req;
        if (pick == PICK_ARP) begin
            arp_cur  <= arp_slot;
            mac_mode <= eth_tx_pkg::ETH_TYPE_ARP;
            // a request goes to broadcast.
            dst_mac  <= (arp_slot.opcode == eth_tx_pkg::ARP_OP_REPLY) ?
                        arp_slot.target_mac : '1;
        end else if (pick == PICK_IP) begin
            ip_cur   <= ip_slot;
            mac_mode <= eth_tx_pkg::ETH_TYPE_IP;
            dst_mac  <= ip_slot.dst_mac;
        end
    end

endmodule

// ==== rtl/eth_tx_top.sv ====
`timescale 1ns/1ps

module eth_tx_top (
    input  logic                 clk,
    input  logic                 rst,
    input  eth_tx_pkg::net_cfg_t cfg,
    input  eth_tx_pkg::arp_req_t arp_req,
    input  logic                 arp_valid,
    output logic                 arp_ready,
    input  eth_tx_pkg::ip_req_t  ip_req,
    input  logic                 ip_valid,
    output logic                 ip_ready,
    output logic                 pay_rd,
    input  eth_tx_pkg::byte_t    pay_data,
    output eth_tx_pkg::tx_out_t  tx
);

    logic                   fs;
    logic                   fd;
    eth_tx_pkg::ethertype_t mac_mode;
    eth_tx_pkg::mac_addr_t  dst_mac;
    eth_tx_pkg::arp_req_t   arp_cur;
    eth_tx_pkg::ip_req_t    ip_cur;
    logic                   fs_arp;
    logic                   fd_arp;
    eth_tx_pkg::byte_t      arp_txd;
    logic                   fs_ip;
    logic                   fd_ip;
    eth_tx_pkg::byte_t      ip_txd;

    tx_sched u_sched (
        .clk       (clk),
        .rst       (rst),
        .arp_req   (arp_req),
        .arp_valid (arp_valid),
        .arp_ready (arp_ready),
        .ip_req    (ip_req),
        .ip_valid  (ip_valid),
        .ip_ready  (ip_ready),
        .fs        (fs),
        .fd        (fd),
        .mac_mode  (mac_mode),
        .dst_mac   (dst_mac),
        .arp_cur   (arp_cur),
        .ip_cur    (ip_cur)
    );

    mac_tx u_mac (
        .clk      (clk),
        .rst      (rst),
        .src_mac  (cfg.local_mac),
        .dst_mac  (dst_mac),
        .mac_mode (mac_mode),
        .fs       (fs),
        .fd       (fd),
        .fs_ip    (fs_ip),
        .fd_ip    (fd_ip),
        .ip_txd   (ip_txd),
        .fs_arp   (fs_arp),
        .fd_arp   (fd_arp),
        .arp_txd  (arp_txd),
        .tx       (tx)
    );

    arp_tx u_arp (
        .clk (clk),
        .rst (rst),
        .cfg (cfg),
        .req (arp_cur),
        .fs  (fs_arp),
        .fd  (fd_arp),
        .txd (arp_txd)
    );

    ip_tx u_ip (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .req      (ip_cur),
        .fs       (fs_ip),
        .fd       (fd_ip),
        .txd      (ip_txd),
        .pay_rd   (pay_rd),
        .pay_data (pay_data)
    );

endmodule

// ==== dv/eth_tx_assert.sv ====
`timescale 1ns/1ps

module eth_tx_assert (
    input logic                clk,
    input logic                rst,
    input logic                fs,
    input logic                fd,
    input logic                fs_ip,
    input logic                fd_ip,
    input logic                fs_arp,
    input logic                fd_arp,
    input eth_tx_pkg::tx_out_t tx
);

    // the idle generator has released its done.
    one_generator: assert property (@(posedge clk) disable iff (rst)
        !(fs_arp && fd_ip) && !(fs_ip && fd_arp))
        else $error("a generator holds fd while the other one runs");

    fd_drops_fs: assert property (@(posedge clk) disable iff (rst) fd |=> !fs)
        else $error("fs still high the cycle after fd");

    // bytes of a frame are contiguous.
    frame_contiguous: assert property (@(posedge clk) disable iff (rst)
        (tx.en && !tx.last) |=> tx.en)
        else $error("tx.en dropped inside a frame");

endmodule

bind mac_tx eth_tx_assert u_assert (
    .clk    (clk),
    .rst    (rst),
    .fs     (fs),
    .fd     (fd),
    .fs_ip  (fs_ip),
    .fd_ip  (fd_ip),
    .fs_arp (fs_arp),
    .fd_arp (fd_arp),
    .tx     (tx)
);

// ==== dv/eth_tx_tb.sv ====
`timescale 1ns/1ps

module eth_tx_tb;

    localparam int NUM_TESTS = 10;
    localparam int TIMEOUT   = 2000;   // clock cycles per wait.

    typedef struct packed {
        logic                  is_arp;
        logic [15:0]           op_len;  // arp opcode or ip payload length.
        eth_tx_pkg::mac_addr_t mac;
        eth_tx_pkg::ip_addr_t  ip;
        logic [1:0]            mode;    // 0 drain, 1 pair with next entry, 2 no drain.
        logic                  stall;   // ip_ready expected low when presented.
    } entry_t;

    logic                 clk;
    logic                 rst;
    eth_tx_pkg::net_cfg_t cfg;
    eth_tx_pkg::arp_req_t arp_req;
    logic                 arp_valid;
    logic                 arp_ready;
    eth_tx_pkg::ip_req_t  ip_req;
    logic                 ip_valid;
    logic                 ip_ready;
    logic                 pay_rd;
    eth_tx_pkg::byte_t    pay_data;
    eth_tx_pkg::tx_out_t  tx;

    entry_t               tests [NUM_TESTS];
    string                names [NUM_TESTS];
    int                   test_err [NUM_TESTS];
    int                   order_q [$];       // accepted requests, in frame order.
    int                   len_q [$];
    eth_tx_pkg::byte_t    rx_q [$];
    eth_tx_pkg::byte_t    exp_q [$];
    eth_tx_pkg::byte_t    pay_log [$];
    integer               seed = 32'hb95f;
    logic [15:0]          ip_ident = 16'h0000;
    int                   arp_idx;
    int                   ip_idx;
    int                   cur_len = 0;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    logic                 rd_seen;
    logic                 timed_out;
    int                   i;

    eth_tx_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // tx is registered, so the falling edge sees it settled.
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && tx.en) begin
                rx_q.push_back(tx.data);
                cur_len++;
                if (tx.last) begin
                    len_q.push_back(cur_len);
                    cur_len = 0;
                end
            end
        end
    end

    // payload source, one byte per read, valid the cycle after pay_rd.
    initial begin
        forever begin
            @(negedge clk);
            rd_seen = pay_rd;
            @(posedge clk);
            #1;
            if (rd_seen) begin
                pay_data = 8'($random(seed));
                pay_log.push_back(pay_data);
            end
        end
    end

    task automatic end_run();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic push_field(input logic [47:0] v, input int nbytes);
        int j;
        for (j = nbytes - 1; j >= 0; j--) begin
            exp_q.push_back(v[8*j +: 8]);
        end
    endtask

    function automatic logic [15:0] header_sum(input int base);
        logic [31:0] sum;
        int          j;
        sum = 32'h0;
        for (j = 0; j < 20; j += 2) begin
            sum = sum + {16'h0000, exp_q[base + j], exp_q[base + j + 1]};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    task automatic build_expected(input int k);
        entry_t      e;
        logic [15:0] csum;
        int          j;
        e = tests[k];
        exp_q.delete();
        if (e.is_arp) begin
            push_field((e.op_len == 16'd2) ? e.mac : '1, 6);   // request is broadcast.
            push_field(cfg.local_mac, 6);
            push_field(48'h0806, 2);
            push_field(48'h0001, 2);
            push_field(48'h0800, 2);
            push_field(48'h06, 1);
            push_field(48'h04, 1);
            push_field(48'(e.op_len), 2);
            push_field(cfg.local_mac, 6);
            push_field(48'(cfg.local_ip), 4);
            push_field((e.op_len == 16'd1) ? 48'h0 : e.mac, 6);
            push_field(48'(e.ip), 4);
        end else begin
            push_field(e.mac, 6);
            push_field(cfg.local_mac, 6);
            push_field(48'h0800, 2);
            push_field(48'h4500, 2);
            push_field(48'(16'd20 + e.op_len), 2);
            push_field(48'(ip_ident), 2);
            push_field(48'h4000, 2);
            push_field(48'h4011, 2);   // ttl 64, udp.
            push_field(48'h0000, 2);   // checksum, patched below.
            push_field(48'(cfg.local_ip), 4);
            push_field(48'(e.ip), 4);
            csum = header_sum(14);
            exp_q[24] = csum[15:8];
            exp_q[25] = csum[7:0];
            for (j = 0; j < int'(e.op_len); j++) begin
                if (pay_log.size() > 0) exp_q.push_back(pay_log.pop_front());
            end
            ip_ident = ip_ident + 16'd1;
        end
    endtask

    task automatic drive_entry(input int k);
        if (tests[k].is_arp) begin
            arp_req = '{opcode: tests[k].op_len, target_mac: tests[k].mac,
                        target_ip: tests[k].ip};
            arp_valid = 1'b1;
            arp_idx   = k;
        end else begin
            ip_req = '{dst_mac: tests[k].mac, dst_ip: tests[k].ip,
                       len: tests[k].op_len[7:0]};
            ip_valid = 1'b1;
            ip_idx   = k;
        end
    endtask

    task automatic wait_accept();
        int   n;
        logic arp_acc;
        logic ip_acc;
        n = 0;
        while ((arp_valid || ip_valid) && n < TIMEOUT) begin
            @(negedge clk);
            arp_acc = arp_valid && arp_ready;
            ip_acc  = ip_valid && ip_ready;
            if (n == 0 && ip_valid && tests[ip_idx].stall && ip_ready) begin
                $display("[FAIL] %s ip_ready expected 0 actual 1", names[ip_idx]);
                test_err[ip_idx]++;
                errors++;
            end
            @(posedge clk);
            #1;
            if (arp_acc) begin   // arp first on a tie.
                arp_valid = 1'b0;
                order_q.push_back(arp_idx);
            end
            if (ip_acc) begin
                ip_valid = 1'b0;
                order_q.push_back(ip_idx);
            end
            n++;
        end
        if (arp_valid || ip_valid) begin
            $display("timeout waiting for a request to be accepted");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_frame(input int k);
        int                n;
        int                len;
        int                bad;
        eth_tx_pkg::byte_t got;
        n = 0;
        while (len_q.size() == 0 && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (len_q.size() == 0) begin
            $display("timeout waiting for the %s frame on tx", names[k]);
            errors++;
            timed_out = 1'b1;
        end else begin
            build_expected(k);
            len = len_q.pop_front();
            bad = 0;
            if (len != exp_q.size()) begin
                $display("[FAIL] %s frame length expected %0d actual %0d",
                         names[k], exp_q.size(), len);
                bad++;
            end
            for (n = 0; n < len; n++) begin
                got = rx_q.pop_front();
                if (n < exp_q.size() && got != exp_q[n]) begin
                    $display("[FAIL] %s byte %0d expected %02h actual %02h",
                             names[k], n, exp_q[n], got);
                    bad++;
                end
            end
            errors += bad;
            bad += test_err[k];
            tests_run++;
            if (bad != 0) tests_failed++;
            $display("test %s %s, %0d bytes", names[k], (bad == 0) ? "ok" : "mismatch", len);
        end
    endtask

    initial begin
        rst       = 1'b1;
        cfg       = '{local_mac: 48'h02_00_5e_10_20_30, local_ip: 32'hc0a8_0164};
        arp_req   = '0;
        arp_valid = 1'b0;
        ip_req    = '0;
        ip_valid  = 1'b0;
        pay_data  = 8'h00;
        arp_idx   = 0;
        ip_idx    = 0;
        timed_out = 1'b0;
        // arp, opcode or length, mac, ip, mode, stall.
        tests[0] = '{1'b1, 16'd1, 48'h02_11_22_33_44_55, 32'hc0a8_0107, 2'd0, 1'b0};
        tests[1] = '{1'b1, 16'd2, 48'h02_aa_bb_cc_dd_ee, 32'hc0a8_0109, 2'd0, 1'b0};
        tests[2] = '{1'b0, 16'd1, 48'h02_10_00_00_00_01, 32'hc0a8_0201, 2'd0, 1'b0};
        tests[3] = '{1'b0, 16'd17, 48'h02_10_00_00_00_02, 32'hc0a8_0202, 2'd0, 1'b0};
        tests[4] = '{1'b0, 16'd255, 48'h02_10_00_00_00_03, 32'h0a00_0003, 2'd0, 1'b0};
        tests[5] = '{1'b1, 16'd1, 48'h00_00_00_00_00_00, 32'hc0a8_0110, 2'd1, 1'b0};
        tests[6] = '{1'b0, 16'd40, 48'h02_10_00_00_00_04, 32'hc0a8_0204, 2'd0, 1'b0};
        tests[7] = '{1'b0, 16'd8, 48'h02_10_00_00_00_05, 32'hc0a8_0205, 2'd2, 1'b0};
        tests[8] = '{1'b0, 16'd12, 48'h02_10_00_00_00_06, 32'hc0a8_0206, 2'd2, 1'b1};
        tests[9] = '{1'b0, 16'd5, 48'h02_10_00_00_00_07, 32'hc0a8_0207, 2'd0, 1'b1};
        names[0] = "arp_request";
        names[1] = "arp_reply";
        names[2] = "ip_len_1";
        names[3] = "ip_len_17";
        names[4] = "ip_len_255";
        names[5] = "arp_with_ip";
        names[6] = "ip_after_arp";
        names[7] = "ip_first";
        names[8] = "ip_pending";
        names[9] = "ip_backpressure";
        for (i = 0; i < NUM_TESTS; i++) begin
            test_err[i] = 0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        i = 0;
        while (i < NUM_TESTS && !timed_out) begin
            drive_entry(i);
            if (tests[i].mode == 2'd1) begin   // same cycle as the next entry.
                i++;
                drive_entry(i);
            end
            wait_accept();
            if (tests[i].mode == 2'd0) begin
                while (order_q.size() > 0 && !timed_out) begin
                    check_frame(order_q.pop_front());
                end
            end
            i++;
        end
        if (!timed_out && (len_q.size() != 0 || rx_q.size() != 0)) begin
            $display("extra bytes seen on tx after the last frame");
            errors++;
        end
        if (!timed_out && pay_log.size() != 0) begin
            $display("payload bytes were read but never sent");
            errors++;
        end
        end_run();
    end

endmodule

// ==== eth_tx.f ====
rtl/eth_tx_pkg.sv
rtl/mac_tx.sv
rtl/arp_tx.sv
rtl/ip_tx.sv
rtl/tx_sched.sv
rtl/eth_tx_top.sv
dv/eth_tx_assert.sv
dv/eth_tx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module eth_tx_tb \
    -f eth_tx.f --Mdir obj_dir -o eth_tx_sim

./obj_dir/eth_tx_sim | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
